// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  # packages first, then RTL bottom up
  - logic/fetch_pkg.sv
  - logic/bus_pkg.sv
  - logic/start_manager.sv
  - logic/bus_port.sv
  - logic/cmd_fetch.sv
  - logic/fetch_front_end.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/fetch_front_end_props.sv
      - verification/fetch_front_end_tb.sv

// ==== fetch_front_end.f ====
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/start_manager.sv
logic/bus_port.sv
logic/cmd_fetch.sv
logic/fetch_front_end.sv
verification/tb_clock.sv
verification/fetch_front_end_props.sv
verification/fetch_front_end_tb.sv

// ==== logic/bus_pkg.sv ====
package bus_pkg;

  // transfer direction
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // master side, held stable with valid high until done
  typedef struct packed {
    logic             valid;
    bus_op_e          op;
    fetch_pkg::addr_t addr;
    fetch_pkg::data_t wdata;
  } bus_req_t;

  // slave side, done is a single cycle pulse
  // rdata only meaningful with done on a read
  typedef struct packed {
    logic             done;
    fetch_pkg::data_t rdata;
  } bus_rsp_t;

  // who currently holds the shared bus
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_START = 2'd1,
    OWN_FETCH = 2'd2
  } bus_owner_e;

endpackage

// ==== logic/bus_port.sv ====
module bus_port (
  input  logic               clk,
  input  logic               rst,
  input  bus_pkg::bus_req_t  start_req,
  output bus_pkg::bus_rsp_t  start_rsp,
  input  bus_pkg::bus_req_t  fetch_req,
  output bus_pkg::bus_rsp_t  fetch_rsp,
  output bus_pkg::bus_req_t  mem_req,
  input  bus_pkg::bus_rsp_t  mem_rsp
);

  bus_pkg::bus_owner_e owner;
  bus_pkg::bus_owner_e grant;
  bus_pkg::bus_req_t   grant_req;
  bus_pkg::bus_req_t   req_q;

  // fixed priority, start manager first
  // only looked at while the bus is free
  always_comb begin
    grant     = bus_pkg::OWN_NONE;
    grant_req = start_req;
    if (owner == bus_pkg::OWN_NONE) begin
      if (start_req.valid) begin
        grant = bus_pkg::OWN_START;
      end else if (fetch_req.valid) begin
        grant     = bus_pkg::OWN_FETCH;
        grant_req = fetch_req;
      end
    end
  end

  // owner claimed with the request, released on done
  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= bus_pkg::OWN_NONE;
    end else if (owner == bus_pkg::OWN_NONE) begin
      owner <= grant;
    end else if (mem_rsp.done) begin
      owner <= bus_pkg::OWN_NONE;
    end
  end

  // request captured once per grant and then held
  always_ff @(posedge clk) begin
    if (grant != bus_pkg::OWN_NONE) begin
      req_q <= grant_req;
    end
  end

  // outgoing valid is simply bus ownership
  always_comb begin
    mem_req       = req_q;
    mem_req.valid = (owner != bus_pkg::OWN_NONE);
  end

  // done and read data to the owner only
  assign start_rsp.done  = mem_rsp.done && (owner == bus_pkg::OWN_START);
  assign start_rsp.rdata = (owner == bus_pkg::OWN_START) ? mem_rsp.rdata : '0;

  assign fetch_rsp.done  = mem_rsp.done && (owner == bus_pkg::OWN_FETCH);
  assign fetch_rsp.rdata = (owner == bus_pkg::OWN_FETCH) ? mem_rsp.rdata : '0;

endmodule

// ==== logic/cmd_fetch.sv ====
module cmd_fetch (
  input  logic               clk,
  input  logic               rst,
  input  fetch_pkg::ptr_t    ptr,
  output logic               ready,
  output logic               idle,
  output bus_pkg::bus_req_t  req,
  input  bus_pkg::bus_rsp_t  rsp,
  output fetch_pkg::cmd_t    cmd_out,
  input  logic               credit_return
);

  logic                              busy;
  logic                              take;
  logic                              push;
  logic                              pop;
  fetch_pkg::addr_t                  rd_addr;
  fetch_pkg::addr_t                  buf_addr [fetch_pkg::BUF_DEPTH];
  fetch_pkg::data_t                  buf_data [fetch_pkg::BUF_DEPTH];
  logic [fetch_pkg::BUF_IDX_W-1:0]   wr_idx;
  logic [fetch_pkg::BUF_IDX_W-1:0]   rd_idx;
  logic [fetch_pkg::BUF_IDX_W:0]     count;
  fetch_pkg::credit_t                credits;

  // one read at a time, and room for its result
  assign ready = !busy && (count != fetch_pkg::BUF_DEPTH);
  assign idle  = !busy && (count == '0);

  assign take = ptr.valid && ready;
  assign push = busy && rsp.done;
  // send whenever something is buffered and the executor has room
  assign pop  = (count != '0) && (credits != '0);

  // read raised in the handoff cycle, then held from rd_addr
  assign req.valid = busy || take;
  assign req.op    = bus_pkg::BUS_READ;
  assign req.addr  = busy ? rd_addr : ptr.addr;
  assign req.wdata = '0;

  assign cmd_out.valid   = pop;
  assign cmd_out.addr    = buf_addr[rd_idx];
  assign cmd_out.command = buf_data[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      wr_idx  <= '0;
      rd_idx  <= '0;
      count   <= '0;
      credits <= fetch_pkg::credit_t'(fetch_pkg::CMD_CREDITS);
    end else begin
      // take needs !busy and push needs busy, never both
      if (take) begin
        busy <= 1'b1;
      end else if (push) begin
        busy <= 1'b0;
      end
      // indices wrap naturally
      if (push) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (pop) begin
        rd_idx <= rd_idx + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // send and return together cancel out
      case ({pop, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rd_addr <= ptr.addr;
    end
    // result stored with the address it came from
    if (push) begin
      buf_addr[wr_idx] <= rd_addr;
      buf_data[wr_idx] <= rsp.rdata;
    end
  end

endmodule

// ==== logic/fetch_front_end.sv ====
module fetch_front_end (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               halt,
  input  fetch_pkg::addr_t   base_addr,
  output bus_pkg::bus_req_t  mem_req,
  input  bus_pkg::bus_rsp_t  mem_rsp,
  output fetch_pkg::cmd_t    cmd_out,
  input  logic               credit_return,
  output logic               running
);

  // pointer handoff
  fetch_pkg::ptr_t   ptr;
  logic              fetch_ready;
  logic              fetch_idle;

  // client sides of the shared bus
  bus_pkg::bus_req_t start_req;
  bus_pkg::bus_rsp_t start_rsp;
  bus_pkg::bus_req_t fetch_req;
  bus_pkg::bus_rsp_t fetch_rsp;

  start_manager i_start_manager (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .halt        (halt),
    .base_addr   (base_addr),
    .fetch_ready (fetch_ready),
    .fetch_idle  (fetch_idle),
    .ptr         (ptr),
    .req         (start_req),
    .rsp         (start_rsp),
    .running     (running)
  );

  bus_port i_bus_port (
    .clk       (clk),
    .rst       (rst),
    .start_req (start_req),
    .start_rsp (start_rsp),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  cmd_fetch i_cmd_fetch (
    .clk           (clk),
    .rst           (rst),
    .ptr           (ptr),
    .ready         (fetch_ready),
    .idle          (fetch_idle),
    .req           (fetch_req),
    .rsp           (fetch_rsp),
    .cmd_out       (cmd_out),
    .credit_return (credit_return)
  );

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  // word address and data widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // executor credit counter width, must hold CMD_CREDITS
  localparam int CREDIT_W = 3;

  // IP register sits this many words above the register block base
  localparam int REG_IP = 3;

  // command slots held by the executor
  localparam int CMD_CREDITS = 4;

  // fetch output buffer, power of two so the indices wrap
  localparam int BUF_DEPTH = 2;
  localparam int BUF_IDX_W = $clog2(BUF_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // command pointer from start manager to fetch stage
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ptr_t;

  // fetched command toward the executor
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t command;
  } cmd_t;

endpackage

// ==== logic/start_manager.sv ====
module start_manager (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               halt,
  input  fetch_pkg::addr_t   base_addr,
  input  logic               fetch_ready,
  input  logic               fetch_idle,
  output fetch_pkg::ptr_t    ptr,
  output bus_pkg::bus_req_t  req,
  input  bus_pkg::bus_rsp_t  rsp,
  output logic               running
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ_IP,
    S_ISSUE,
    S_DRAIN,
    S_WRITE_IP
  } state_e;

  state_e           state;
  state_e           state_next;
  fetch_pkg::addr_t ip_addr;
  fetch_pkg::addr_t ip_addr_new;
  fetch_pkg::addr_t cmd_ptr;
  logic             halt_pend;
  logic             issue;

  // IP register location for the current base
  assign ip_addr_new = base_addr + fetch_pkg::addr_t'(fetch_pkg::REG_IP);

  // hand out a pointer only while fetch can take it
  // halt cycle itself already blocks the handoff
  assign issue = (state == S_ISSUE) && fetch_ready && !halt;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_next = S_READ_IP;
        end
      end
      S_READ_IP: begin
        // halt during the IP read skips issuing entirely
        if (rsp.done) begin
          state_next = (halt || halt_pend) ? S_DRAIN : S_ISSUE;
        end
      end
      S_ISSUE: begin
        if (halt) begin
          state_next = S_DRAIN;
        end
      end
      S_DRAIN: begin
        // wait until every fetched command has left the buffer
        if (fetch_idle) begin
          state_next = S_WRITE_IP;
        end
      end
      S_WRITE_IP: begin
        if (rsp.done) begin
          state_next = S_IDLE;
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      halt_pend <= 1'b0;
    end else begin
      state     <= state_next;
      // remember a halt that arrives before the IP is known
      halt_pend <= (state == S_READ_IP) && !rsp.done && (halt_pend || halt);
    end
  end

  always_ff @(posedge clk) begin
    // base latched once per run
    if ((state == S_IDLE) && start) begin
      ip_addr <= ip_addr_new;
    end
    // stored IP becomes the first pointer
    if ((state == S_READ_IP) && rsp.done) begin
      cmd_ptr <= fetch_pkg::addr_t'(rsp.rdata);
    end else if (issue) begin
      cmd_ptr <= cmd_ptr + 1'b1;
    end
  end

  // read request goes out with the start pulse itself
  // write request goes out as soon as fetch is idle
  assign req.valid = ((state == S_IDLE) && start) ||
                     (state == S_READ_IP) ||
                     ((state == S_DRAIN) && fetch_idle) ||
                     (state == S_WRITE_IP);
  assign req.op    = ((state == S_IDLE) || (state == S_READ_IP)) ?
                     bus_pkg::BUS_READ : bus_pkg::BUS_WRITE;
  assign req.addr  = (state == S_IDLE) ? ip_addr_new : ip_addr;
  // next unfetched pointer goes back into the IP register
  assign req.wdata = fetch_pkg::data_t'(cmd_ptr);

  assign ptr.valid = issue;
  assign ptr.addr  = cmd_ptr;

  // drops the cycle after the IP write completes
  assign running = (state != S_IDLE);

endmodule

// ==== verification/fetch_front_end_props.sv ====
module fetch_front_end_props (
  input  logic                 clk,
  input  logic                 rst,
  input  bus_pkg::bus_req_t    mem_req,
  input  bus_pkg::bus_rsp_t    mem_rsp,
  input  fetch_pkg::cmd_t      cmd_out,
  input  logic                 credit_return,
  input  logic                 running,
  input  fetch_pkg::credit_t   credits
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // commands the executor holds, counted from the outside
  fetch_pkg::credit_t in_use;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_use <= '0;
    end else begin
      in_use <= in_use + fetch_pkg::credit_t'(cmd_out.valid) -
                fetch_pkg::credit_t'(credit_return);
    end
  end

  // request held unchanged until the memory ends it
  a_req_held : assert property (@(posedge clk) disable iff (rst)
    mem_req.valid && !mem_rsp.done |=> mem_req.valid && $stable(mem_req))
  else begin
    $error("memory request changed or dropped before done");
    fail_count++;
  end

  // executor needs a free slot for every send
  a_send_needs_credit : assert property (@(posedge clk) disable iff (rst)
    cmd_out.valid |-> (in_use < fetch_pkg::credit_t'(fetch_pkg::CMD_CREDITS)))
  else begin
    $error("command sent with zero credits");
    fail_count++;
  end

  a_credit_bound : assert property (@(posedge clk) disable iff (rst)
    credits <= fetch_pkg::credit_t'(fetch_pkg::CMD_CREDITS))
  else begin
    $error("credit count above executor slots");
    fail_count++;
  end

  // quiet outputs right after reset
  a_reset_quiet : assert property (@(posedge clk)
    rst |=> !running && !mem_req.valid && !cmd_out.valid)
  else begin
    $error("outputs active after reset");
    fail_count++;
  end

endmodule

// ==== verification/fetch_front_end_tb.sv ====
module fetch_front_end_tb;

  // command words are address xor this key
  localparam logic [31:0] MEM_KEY = 32'h5A5A_C3C3;
  localparam int N_ROWS = 5;
  localparam int WD_MARGIN = 400;
  localparam int HOLD_CYCLES = 30;
  localparam int WR_SLOTS = 8;
  localparam logic [31:0] SEED = 32'd80;

  // one test run, init_ip of zero means resume from the written-back IP
  typedef struct packed {
    fetch_pkg::addr_t base;
    fetch_pkg::addr_t init_ip;
    logic [7:0]       n_cmds;
    logic [7:0]       max_lat;
  } row_t;

  logic              clk;
  logic              rst;
  logic              start;
  logic              halt;
  fetch_pkg::addr_t  base_addr;
  bus_pkg::bus_req_t mem_req;
  bus_pkg::bus_rsp_t mem_rsp = '0;
  fetch_pkg::cmd_t   cmd_out;
  logic              credit_return = 1'b0;
  logic              running;

  // row context, written by the main sequence
  fetch_pkg::addr_t  row_ip = '0;
  fetch_pkg::addr_t  ip_loc = '0;
  logic [7:0]        row_lat = 8'd1;
  logic              hold = 1'b0;
  int                rx_base = 0;

  // memory model state
  logic              mem_active;
  logic [7:0]        wait_cnt;
  logic [31:0]       mem_rng;
  logic              stop_check;
  int                req_count = 0;
  fetch_pkg::addr_t  last_req_addr;
  bus_pkg::bus_op_e  last_req_op;
  int                last_req_cyc;
  fetch_pkg::addr_t  wr_addr [WR_SLOTS];
  fetch_pkg::data_t  wr_data [WR_SLOTS];
  int                n_writes = 0;
  fetch_pkg::addr_t  last_wr_addr;
  fetch_pkg::data_t  last_wr_data;

  // executor model state
  int                rx_total = 0;
  int                owed = 0;
  logic [1:0]        ret_wait;
  logic [31:0]       exec_rng;
  int                cyc = 0;

  tb_clock i_tb_clock (
    .clk (clk)
  );

  fetch_front_end i_fetch_front_end (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .halt          (halt),
    .base_addr     (base_addr),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .cmd_out       (cmd_out),
    .credit_return (credit_return),
    .running       (running)
  );

  bind fetch_front_end fetch_front_end_props i_fetch_front_end_props (
    .clk           (clk),
    .rst           (rst),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .cmd_out       (cmd_out),
    .credit_return (credit_return),
    .running       (running),
    .credits       (i_cmd_fetch.credits)
  );

  function automatic row_t get_row(input int i);
    row_t r;
    case (i)
      0:       r = '{base: 32'h0000_1000, init_ip: 32'h0000_4000, n_cmds: 8'd6, max_lat: 8'd3};
      1:       r = '{base: 32'h0000_2000, init_ip: 32'h0000_8000, n_cmds: 8'd9, max_lat: 8'd5};
      // same base as row 0
      2:       r = '{base: 32'h0000_1000, init_ip: 32'h0, n_cmds: 8'd5, max_lat: 8'd2};
      3:       r = '{base: 32'h0000_3000, init_ip: 32'h0001_0000, n_cmds: 8'd12, max_lat: 8'd7};
      default: r = '{base: 32'h0000_2000, init_ip: 32'h0, n_cmds: 8'd4, max_lat: 8'd1};
    endcase
    return r;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // latest recorded write to an address
  task automatic lookup_word(input fetch_pkg::addr_t addr, output logic found,
                             output fetch_pkg::data_t data);
    found = 1'b0;
    data  = '0;
    for (int i = 0; i < n_writes; i++) begin
      if (wr_addr[i] == addr) begin
        found = 1'b1;
        data  = wr_data[i];
      end
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // a failed bound assertion ends the run at once
  always @(posedge clk) begin
    if (i_fetch_front_end.i_fetch_front_end_props.fail_count != 0) begin
      fail_run("bound assertions reported errors during the run");
    end
  end

  // memory: random latency, IP location returns the row IP, writes recorded
  always @(posedge clk) begin
    if (rst) begin
      mem_rsp    <= '0;
      mem_active <= 1'b0;
      wait_cnt   <= '0;
      mem_rng    <= SEED;
      stop_check <= 1'b0;
    end else begin
      stop_check <= 1'b0;
      if (stop_check) begin
        check_value("running after IP write", 32'(running), 32'd0);
      end
      if (mem_rsp.done) begin
        mem_rsp.done <= 1'b0;
        mem_active   <= 1'b0;
        if (mem_req.op == bus_pkg::BUS_WRITE) begin
          check_value("running during IP write", 32'(running), 32'd1);
          stop_check <= 1'b1;
        end
      end else if (mem_req.valid) begin
        if (!mem_active) begin
          mem_active    <= 1'b1;
          mem_rng       <= xorshift32(mem_rng);
          wait_cnt      <= 8'(mem_rng % 32'(row_lat));
          req_count     <= req_count + 1;
          last_req_addr <= mem_req.addr;
          last_req_op   <= mem_req.op;
          last_req_cyc  <= cyc;
        end else if (wait_cnt != '0) begin
          wait_cnt <= wait_cnt - 1'b1;
        end else begin
          mem_rsp.done  <= 1'b1;
          mem_rsp.rdata <= (mem_req.addr == ip_loc) ? row_ip : (mem_req.addr ^ MEM_KEY);
          if (mem_req.op == bus_pkg::BUS_WRITE) begin
            if (n_writes == WR_SLOTS) begin
              fail_run("memory model ran out of write records");
            end
            wr_addr[n_writes] <= mem_req.addr;
            wr_data[n_writes] <= mem_req.wdata;
            n_writes          <= n_writes + 1;
            last_wr_addr      <= mem_req.addr;
            last_wr_data      <= mem_req.wdata;
          end
        end
      end
    end
  end

  // executor: in-order check, credits returned after a random delay
  always @(posedge clk) begin : executor_model
    int               owed_next;
    fetch_pkg::addr_t exp_addr;
    owed_next = owed;
    exp_addr  = row_ip + fetch_pkg::addr_t'(rx_total - rx_base);
    if (rst) begin
      credit_return <= 1'b0;
      owed          <= 0;
      ret_wait      <= '0;
      exec_rng      <= xorshift32(SEED);
    end else begin
      credit_return <= 1'b0;
      if (cmd_out.valid) begin
        check_value("cmd_out.addr", cmd_out.addr, exp_addr);
        check_value("cmd_out.command", cmd_out.command, exp_addr ^ MEM_KEY);
        if (owed >= fetch_pkg::CMD_CREDITS) begin
          fail_run("command arrived while every executor slot was taken");
        end
        rx_total  <= rx_total + 1;
        owed_next = owed_next + 1;
      end
      if (!hold && (owed != 0)) begin
        if (ret_wait == '0) begin
          credit_return <= 1'b1;
          owed_next = owed_next - 1;
          exec_rng      <= xorshift32(exec_rng);
          ret_wait      <= exec_rng[1:0];
        end else begin
          ret_wait <= ret_wait - 1'b1;
        end
      end
      owed <= owed_next;
    end
  end

  // limit from table length and latencies
  initial begin : watchdog
    row_t r;
    int   limit;
    limit = WD_MARGIN;
    for (int i = 0; i < N_ROWS; i++) begin
      r     = get_row(i);
      limit = limit + (int'(r.n_cmds) + 4) * (int'(r.max_lat) + 8) + HOLD_CYCLES;
    end
    repeat (limit) @(posedge clk);
    fail_run("run did not finish within its cycle limit");
  end

  initial begin : main_sequence
    row_t             r;
    logic             found;
    fetch_pkg::data_t stored;
    fetch_pkg::addr_t exp_ip;
    int               req_base;
    int               wr_base;
    int               start_cyc;
    rst       = 1'b1;
    start     = 1'b0;
    halt      = 1'b0;
    base_addr = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("running", 32'(running), 32'd0);
    check_value("mem_req.valid", 32'(mem_req.valid), 32'd0);
    check_value("cmd_out.valid", 32'(cmd_out.valid), 32'd0);
    check_value("credits", 32'(i_fetch_front_end.i_cmd_fetch.credits), fetch_pkg::CMD_CREDITS);

    for (int i = 0; i < N_ROWS; i++) begin
      r = get_row(i);
      lookup_word(r.base + fetch_pkg::REG_IP, found, stored);
      exp_ip = r.init_ip;
      if (r.init_ip == '0) begin
        if (!found) begin
          fail_run("resumed row found no written-back IP");
        end
        exp_ip = stored;
      end
      row_ip    <= exp_ip;
      ip_loc    <= r.base + fetch_pkg::REG_IP;
      row_lat   <= r.max_lat;
      rx_base   <= rx_total;
      hold      <= 1'b1;
      base_addr <= r.base;
      req_base  = req_count;
      wr_base   = n_writes;
      start_cyc = cyc;
      start     <= 1'b1;
      @(posedge clk);
      start <= 1'b0;

      // first bus access reads the IP register
      while (req_count == req_base) @(posedge clk);
      check_value("first mem_req.op", 32'(last_req_op), 32'(bus_pkg::BUS_READ));
      check_value("first mem_req.addr", last_req_addr, r.base + fetch_pkg::REG_IP);
      check_value("start to request cycles", 32'(last_req_cyc - start_cyc), 32'd2);

      // executor withholds credits, only its slots may fill
      while ((rx_total - rx_base) < fetch_pkg::CMD_CREDITS) @(posedge clk);
      repeat (HOLD_CYCLES) @(posedge clk);
      check_value("commands while held", 32'(rx_total - rx_base), fetch_pkg::CMD_CREDITS);
      hold <= 1'b0;

      while ((rx_total - rx_base) < int'(r.n_cmds)) @(posedge clk);
      halt <= 1'b1;
      @(posedge clk);
      halt <= 1'b0;
      while (running) @(posedge clk);

      // next unfetched pointer written back
      check_value("IP write count", 32'(n_writes - wr_base), 32'd1);
      check_value("IP write addr", last_wr_addr, r.base + fetch_pkg::REG_IP);
      check_value("IP write data", last_wr_data, exp_ip + 32'(rx_total - rx_base));

      // all credits home before the next row
      while (owed != 0) @(posedge clk);
      @(posedge clk);
      check_value("credits at idle", 32'(i_fetch_front_end.i_cmd_fetch.credits),
                  fetch_pkg::CMD_CREDITS);
    end

    if (i_fetch_front_end.i_fetch_front_end_props.fail_count != 0) begin
      fail_run("bound assertions reported errors during the run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  // full period in time units
  localparam int PERIOD = 8;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule
